/* rtl/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Machine word width in bits
`define DATA_WIDTH 32

// Instruction memory depth, log2 of words
`define IMEM_ADDR_BITS 6

// Wishbone byte address width
`define WB_ADDR_WIDTH 32

`endif

/* rtl/isaPkg.sv */
`include "core_settings.svh"

package isaPkg;

   // Register number, r0 reads as zero
   typedef logic [4:0] regIndex;

   typedef logic [`DATA_WIDTH-1:0] word;

   typedef logic [31:0] instruction;

   // Primary opcode in bits 31:26
   typedef enum logic [5:0] {
      opSpecial  = 6'b000000,
      opSpecial2 = 6'b011100,
      opAddi     = 6'b001000,
      opOri      = 6'b001101,
      opLw       = 6'b100011,
      opSw       = 6'b101011,
      opBeq      = 6'b000100,
      opBne      = 6'b000101
   } opcode;

   // Function field in bits 5:0
   typedef enum logic [5:0] {
      fnAdd = 6'b100000,
      fnSub = 6'b100010,
      fnAnd = 6'b100100,
      fnOr  = 6'b100101,
      fnSlt = 6'b101010,
      fnMul = 6'b000010   // only under opSpecial2
   } funct;

endpackage

/* rtl/pipePkg.sv */
package pipePkg;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSlt,
      aluMul
   } aluOp;

   // IF/ID
   typedef struct packed {
      logic               valid;
      isaPkg::word        pc;
      isaPkg::instruction instr;
   } ifId;

   // ID/EX, operands already muxed
   typedef struct packed {
      logic            valid;
      isaPkg::word     opA;
      isaPkg::word     opB;
      isaPkg::word     storeData;
      aluOp            operation;
      logic            memRead;
      logic            memWrite;
      logic            regWrite;
      isaPkg::regIndex dest;
   } idEx;

   // EX/MEM
   typedef struct packed {
      logic            valid;
      isaPkg::word     result;
      isaPkg::word     storeData;
      logic            memRead;
      logic            memWrite;
      logic            regWrite;
      isaPkg::regIndex dest;
   } exMem;

   // MEM/WB
   typedef struct packed {
      logic            valid;
      isaPkg::word     result;
      logic            regWrite;
      isaPkg::regIndex dest;
   } memWb;

   // Producer seen from decode
   typedef struct packed {
      logic            regWrite;
      isaPkg::regIndex dest;
   } destInfo;

endpackage

/* rtl/hazardDetection.sv */
`timescale 1ns/1ps

module hazardDetection (
   input  isaPkg::regIndex  rs,
   input  isaPkg::regIndex  rt,
   input  logic             readsRt,
   input  pipePkg::destInfo exDest,
   input  pipePkg::destInfo memDest,
   output logic             stall
);

   logic rsOnEx;
   logic rsOnMem;
   logic rtOnEx;
   logic rtOnMem;

   // Source matches a live producer, r0 never does
   function automatic logic dependsOn(isaPkg::regIndex src, pipePkg::destInfo producer);
      return producer.regWrite && (src != '0) && (src == producer.dest);
   endfunction

   // Instruction one ahead, now in execute
   assign rsOnEx  = dependsOn(rs, exDest);
   assign rtOnEx  = dependsOn(rt, exDest);

   // Two ahead, now in memory
   assign rsOnMem = dependsOn(rs, memDest);
   assign rtOnMem = dependsOn(rt, memDest);

   // Writeback is bypassed in the register file, so no third check
   assign stall = rsOnEx || rsOnMem || (readsRt && (rtOnEx || rtOnMem));

endmodule

/* rtl/fetchStage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module fetchStage (
   input  logic                       Clock,
   input  logic                       reset,
   input  logic                       stall,
   input  logic                       freeze,
   input  logic                       redirect,
   input  isaPkg::word                target,
   input  logic                       loadEnable,
   input  logic [`IMEM_ADDR_BITS-1:0] loadAddr,
   input  isaPkg::instruction         loadData,
   output pipePkg::ifId               fetched
);

   isaPkg::word        pc;
   isaPkg::instruction imem [2**`IMEM_ADDR_BITS];
   isaPkg::instruction imemData;

   // Program load, only used while reset is held
   always_ff @(posedge Clock) begin
      if (loadEnable) begin
         imem[loadAddr] <= loadData;
      end
   end

   // Byte pc to word index
   assign imemData = imem[pc[`IMEM_ADDR_BITS+1:2]];

   always_ff @(posedge Clock) begin
      if (reset) begin
         pc            <= '0;
         fetched.valid <= 1'b0;
      end else if (!stall && !freeze) begin
         // Slot behind a taken branch is squashed
         fetched.valid <= !redirect;
         fetched.pc    <= pc;
         fetched.instr <= imemData;
         pc            <= redirect ? target : pc + isaPkg::word'(4);
      end
   end

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
   input  logic             Clock,
   input  logic             reset,
   input  logic             freeze,
   input  pipePkg::ifId     fetched,
   input  pipePkg::destInfo exDest,
   input  pipePkg::destInfo memDest,
   input  pipePkg::memWb    writeBack,
   output pipePkg::idEx     decoded,
   output logic             stall,
   output logic             redirect,
   output isaPkg::word      target
);

   isaPkg::word     regs [32];
   isaPkg::opcode   op;
   isaPkg::funct    fn;
   isaPkg::regIndex rs;
   isaPkg::regIndex rt;
   isaPkg::regIndex rd;
   isaPkg::word     rsValue;
   isaPkg::word     rtValue;
   isaPkg::word     immValue;
   logic            writeEnable;
   logic            rType;
   logic            readsRt;
   logic            hazard;
   logic            taken;
   pipePkg::idEx    nextDecoded;

   ////////////////////////////////////////////////////////////////////////////
   // Register file and writeback

   assign writeEnable = writeBack.valid && writeBack.regWrite && (writeBack.dest != '0);

   always_ff @(posedge Clock) begin
      if (writeEnable) begin
         regs[writeBack.dest] <= writeBack.result;
      end
   end

   // Same-cycle write is bypassed to the read ports
   assign rsValue = (rs == '0) ? '0 :
                    (writeEnable && writeBack.dest == rs) ? writeBack.result : regs[rs];
   assign rtValue = (rt == '0) ? '0 :
                    (writeEnable && writeBack.dest == rt) ? writeBack.result : regs[rt];

   ////////////////////////////////////////////////////////////////////////////
   // Field decode

   assign op = isaPkg::opcode'(fetched.instr[31:26]);
   assign fn = isaPkg::funct'(fetched.instr[5:0]);
   assign rs = fetched.instr[25:21];
   assign rt = fetched.instr[20:16];
   assign rd = fetched.instr[15:11];

   assign rType   = (op == isaPkg::opSpecial) || (op == isaPkg::opSpecial2);
   assign readsRt = rType || (op == isaPkg::opSw) || (op == isaPkg::opBeq) ||
                    (op == isaPkg::opBne);

   // ORI zero-extends, everything else sign-extends
   assign immValue = (op == isaPkg::opOri) ? isaPkg::word'(fetched.instr[15:0]) :
                                             isaPkg::word'($signed(fetched.instr[15:0]));

   hazardDetection u_hazard (
      .rs      (rs),
      .rt      (rt),
      .readsRt (readsRt),
      .exDest  (exDest),
      .memDest (memDest),
      .stall   (hazard)
   );

   assign stall = fetched.valid && hazard;

   // Branches resolve here, only once operands are settled
   assign taken    = ((op == isaPkg::opBeq) && (rsValue == rtValue)) ||
                     ((op == isaPkg::opBne) && (rsValue != rtValue));
   assign redirect = fetched.valid && !stall && taken;
   assign target   = fetched.pc + isaPkg::word'(4) + (immValue << 2);

   always_comb begin
      nextDecoded           = '0;
      nextDecoded.valid     = fetched.valid && !stall;
      nextDecoded.opA       = rsValue;
      nextDecoded.opB       = rType ? rtValue : immValue;
      nextDecoded.storeData = rtValue;
      nextDecoded.operation = pipePkg::aluAdd;
      case (op)
         isaPkg::opSpecial, isaPkg::opSpecial2: begin
            nextDecoded.regWrite = 1'b1;
            nextDecoded.dest     = rd;
            case (fn)
               isaPkg::fnSub: nextDecoded.operation = pipePkg::aluSub;
               isaPkg::fnAnd: nextDecoded.operation = pipePkg::aluAnd;
               isaPkg::fnOr:  nextDecoded.operation = pipePkg::aluOr;
               isaPkg::fnSlt: nextDecoded.operation = pipePkg::aluSlt;
               isaPkg::fnMul: nextDecoded.operation = pipePkg::aluMul;
               default:       nextDecoded.operation = pipePkg::aluAdd;
            endcase
         end
         isaPkg::opAddi: begin
            nextDecoded.regWrite = 1'b1;
            nextDecoded.dest     = rt;
         end
         isaPkg::opOri: begin
            nextDecoded.regWrite  = 1'b1;
            nextDecoded.dest      = rt;
            nextDecoded.operation = pipePkg::aluOr;
         end
         isaPkg::opLw: begin
            nextDecoded.regWrite = 1'b1;
            nextDecoded.dest     = rt;
            nextDecoded.memRead  = 1'b1;
         end
         isaPkg::opSw: begin
            nextDecoded.memWrite = 1'b1;
         end
         // Branches and unknown opcodes leave no side effect
         default: begin
            nextDecoded.regWrite = 1'b0;
         end
      endcase
   end

   // ID/EX, a bubble goes in under stall
   always_ff @(posedge Clock) begin
      if (reset) begin
         decoded.valid <= 1'b0;
      end else if (!freeze) begin
         decoded <= nextDecoded;
      end
   end

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
   input  logic             Clock,
   input  logic             reset,
   input  logic             freeze,
   input  pipePkg::idEx     decoded,
   output pipePkg::destInfo exDest,
   output pipePkg::exMem    executed
);

   isaPkg::word aluResult;

   always_comb begin
      case (decoded.operation)
         pipePkg::aluSub: aluResult = decoded.opA - decoded.opB;
         pipePkg::aluAnd: aluResult = decoded.opA & decoded.opB;
         pipePkg::aluOr:  aluResult = decoded.opA | decoded.opB;
         pipePkg::aluSlt: begin
            aluResult = ($signed(decoded.opA) < $signed(decoded.opB)) ?
                        isaPkg::word'(1) : '0;
         end
         // Low word of the product only
         pipePkg::aluMul: aluResult = decoded.opA * decoded.opB;
         default:         aluResult = decoded.opA + decoded.opB;
      endcase
   end

   // Bubbles must not look like producers
   assign exDest.regWrite = decoded.valid && decoded.regWrite;
   assign exDest.dest     = decoded.dest;

   always_ff @(posedge Clock) begin
      if (reset) begin
         executed.valid <= 1'b0;
      end else if (!freeze) begin
         executed.valid     <= decoded.valid;
         executed.result    <= aluResult;
         executed.storeData <= decoded.storeData;
         executed.memRead   <= decoded.memRead;
         executed.memWrite  <= decoded.memWrite;
         executed.regWrite  <= decoded.regWrite;
         executed.dest      <= decoded.dest;
      end
   end

endmodule

/* rtl/memoryStage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module memoryStage (
   input  logic                      Clock,
   input  logic                      reset,
   input  pipePkg::exMem             executed,
   input  logic                      ack,
   input  isaPkg::word               datMiso,
   output pipePkg::destInfo          memDest,
   output logic                      freeze,
   output logic                      cyc,
   output logic                      stb,
   output logic                      we,
   output logic [`WB_ADDR_WIDTH-1:0] adr,
   output isaPkg::word               datMosi,
   output pipePkg::memWb             writeBack
);

   typedef enum logic {
      idle,
      busy
   } busState;

   busState state;
   logic    access;

   assign access = executed.valid && (executed.memRead || executed.memWrite);

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone classic master

   // Start in the same cycle the access arrives, hold open until ack
   assign cyc     = (state == busy) ? 1'b1 : access;
   assign stb     = cyc;
   assign we      = cyc && executed.memWrite;
   assign adr     = `WB_ADDR_WIDTH'(executed.result);
   assign datMosi = executed.storeData;

   // Whole pipeline waits for the slave
   assign freeze = cyc && !ack;

   always_ff @(posedge Clock) begin
      if (reset) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               if (access && !ack) begin
                  state <= busy;
               end
            end
            busy: begin
               if (ack) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // MEM/WB

   assign memDest.regWrite = executed.valid && executed.regWrite;
   assign memDest.dest     = executed.dest;

   always_ff @(posedge Clock) begin
      if (reset) begin
         writeBack.valid <= 1'b0;
      end else begin
         // Nothing retires while the transfer waits
         writeBack.valid    <= executed.valid && !freeze;
         writeBack.result   <= executed.memRead ? datMiso : executed.result;
         writeBack.regWrite <= executed.regWrite;
         writeBack.dest     <= executed.dest;
      end
   end

endmodule

/* rtl/pipelineTop.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module pipelineTop (
   input  logic                       Clock,
   input  logic                       reset,
   input  logic                       loadEnable,
   input  logic [`IMEM_ADDR_BITS-1:0] loadAddr,
   input  isaPkg::instruction         loadData,
   input  logic                       ack,
   input  isaPkg::word                datMiso,
   output logic                       cyc,
   output logic                       stb,
   output logic                       we,
   output logic [`WB_ADDR_WIDTH-1:0]  adr,
   output isaPkg::word                datMosi
);

   pipePkg::ifId     fetched;
   pipePkg::idEx     decoded;
   pipePkg::exMem    executed;
   pipePkg::memWb    writeBack;
   pipePkg::destInfo exDest;
   pipePkg::destInfo memDest;
   logic             stall;
   logic             redirect;
   logic             freeze;
   isaPkg::word      target;

   fetchStage u_fetch (
      .Clock      (Clock),
      .reset      (reset),
      .stall      (stall),
      .freeze     (freeze),
      .redirect   (redirect),
      .target     (target),
      .loadEnable (loadEnable),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .fetched    (fetched)
   );

   decodeStage u_decode (
      .Clock     (Clock),
      .reset     (reset),
      .freeze    (freeze),
      .fetched   (fetched),
      .exDest    (exDest),
      .memDest   (memDest),
      .writeBack (writeBack),
      .decoded   (decoded),
      .stall     (stall),
      .redirect  (redirect),
      .target    (target)
   );

   executeStage u_execute (
      .Clock    (Clock),
      .reset    (reset),
      .freeze   (freeze),
      .decoded  (decoded),
      .exDest   (exDest),
      .executed (executed)
   );

   memoryStage u_memory (
      .Clock     (Clock),
      .reset     (reset),
      .executed  (executed),
      .ack       (ack),
      .datMiso   (datMiso),
      .memDest   (memDest),
      .freeze    (freeze),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .datMosi   (datMosi),
      .writeBack (writeBack)
   );

endmodule

/* test/tbPrograms.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NumTests = 5;
localparam int MaxWords = 16;

isaPkg::instruction progWords [NumTests][MaxWords];
int                 progLen [NumTests];
isaPkg::word        presetAddr [NumTests][4];
isaPkg::word        presetData [NumTests][4];
int                 presetCount [NumTests];
isaPkg::word        storeAddr [NumTests][4];
isaPkg::word        storeData [NumTests][4];
int                 storeCount [NumTests];

// R-type, rd = rs op rt
function automatic isaPkg::instruction encR(isaPkg::opcode op, isaPkg::funct fn,
                                            isaPkg::regIndex rd, isaPkg::regIndex rs,
                                            isaPkg::regIndex rt);
   return {op, rs, rt, rd, 5'b00000, fn};
endfunction

// I-type, rt is the destination or the store source
function automatic isaPkg::instruction encI(isaPkg::opcode op, isaPkg::regIndex rt,
                                            isaPkg::regIndex rs, logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

task automatic emit(int t, isaPkg::instruction w);
   progWords[t][progLen[t]] = w;
   progLen[t]++;
endtask

task automatic presetWord(int t, isaPkg::word a, isaPkg::word d);
   presetAddr[t][presetCount[t]] = a;
   presetData[t][presetCount[t]] = d;
   presetCount[t]++;
endtask

task automatic expectStore(int t, isaPkg::word a, isaPkg::word d);
   storeAddr[t][storeCount[t]] = a;
   storeData[t][storeCount[t]] = d;
   storeCount[t]++;
endtask

task automatic fillPrograms();
   for (int t = 0; t < NumTests; t++) begin
      progLen[t]     = 0;
      presetCount[t] = 0;
      storeCount[t]  = 0;
   end

   // Back-to-back R-type chain
   emit(0, encI(isaPkg::opAddi, 1, 0, 16'd7));
   emit(0, encI(isaPkg::opAddi, 2, 0, 16'd3));
   emit(0, encR(isaPkg::opSpecial, isaPkg::fnAdd, 3, 1, 2));
   emit(0, encR(isaPkg::opSpecial, isaPkg::fnSub, 4, 3, 2));
   emit(0, encR(isaPkg::opSpecial, isaPkg::fnAnd, 5, 4, 3));
   emit(0, encR(isaPkg::opSpecial, isaPkg::fnOr, 6, 5, 1));
   emit(0, encR(isaPkg::opSpecial, isaPkg::fnSlt, 7, 5, 6));
   emit(0, encI(isaPkg::opSw, 3, 0, 16'h0100));
   emit(0, encI(isaPkg::opSw, 4, 0, 16'h0104));
   emit(0, encI(isaPkg::opSw, 6, 0, 16'h0108));
   emit(0, encI(isaPkg::opSw, 7, 0, 16'h010c));
   expectStore(0, 32'h100, 32'd10);
   expectStore(0, 32'h104, 32'd7);
   expectStore(0, 32'h108, 32'd7);
   expectStore(0, 32'h10c, 32'd1);

   // Immediate extension and low word of the product
   emit(1, encI(isaPkg::opAddi, 1, 0, 16'hfffb));
   emit(1, encI(isaPkg::opOri, 2, 0, 16'h8001));
   emit(1, encI(isaPkg::opAddi, 3, 0, 16'hfffd));
   emit(1, encR(isaPkg::opSpecial2, isaPkg::fnMul, 4, 1, 3));
   emit(1, encR(isaPkg::opSpecial2, isaPkg::fnMul, 6, 1, 2));
   emit(1, encI(isaPkg::opSw, 1, 0, 16'h0200));
   emit(1, encI(isaPkg::opSw, 2, 0, 16'h0204));
   emit(1, encI(isaPkg::opSw, 4, 0, 16'h0208));
   emit(1, encI(isaPkg::opSw, 6, 0, 16'h020c));
   expectStore(1, 32'h200, 32'hffff_fffb);
   expectStore(1, 32'h204, 32'h0000_8001);
   expectStore(1, 32'h208, 32'd15);
   expectStore(1, 32'h20c, 32'hfffd_7ffb);

   // Load-use and memory-stage dependencies
   presetWord(2, 32'h300, 32'h1234_5678);
   presetWord(2, 32'h304, 32'h0000_0010);
   emit(2, encI(isaPkg::opLw, 1, 0, 16'h0300));
   emit(2, encI(isaPkg::opAddi, 2, 1, 16'd1));
   emit(2, encI(isaPkg::opLw, 3, 0, 16'h0304));
   emit(2, encI(isaPkg::opSw, 1, 3, 16'h0300));
   emit(2, encI(isaPkg::opAddi, 5, 0, 16'h0055));
   emit(2, encI(isaPkg::opAddi, 6, 0, 16'd1));
   emit(2, encI(isaPkg::opSw, 5, 0, 16'h0308));
   emit(2, encI(isaPkg::opSw, 2, 0, 16'h0314));
   emit(2, encI(isaPkg::opLw, 7, 0, 16'h0314));
   emit(2, encI(isaPkg::opSw, 7, 0, 16'h0318));
   expectStore(2, 32'h310, 32'h1234_5678);
   expectStore(2, 32'h308, 32'h0000_0055);
   expectStore(2, 32'h314, 32'h1234_5679);
   expectStore(2, 32'h318, 32'h1234_5679);

   // Taken and not-taken branches, skipped stores must not appear
   emit(3, encI(isaPkg::opAddi, 1, 0, 16'd5));
   emit(3, encI(isaPkg::opAddi, 2, 0, 16'd5));
   emit(3, encI(isaPkg::opAddi, 3, 0, 16'd9));
   emit(3, encI(isaPkg::opBeq, 2, 1, 16'd1));
   emit(3, encI(isaPkg::opSw, 1, 0, 16'h0400));
   emit(3, encI(isaPkg::opSw, 2, 0, 16'h0404));
   emit(3, encI(isaPkg::opBne, 2, 1, 16'd1));
   emit(3, encI(isaPkg::opSw, 3, 0, 16'h0408));
   emit(3, encI(isaPkg::opBne, 3, 1, 16'd1));
   emit(3, encI(isaPkg::opSw, 3, 0, 16'h040c));
   emit(3, encI(isaPkg::opBeq, 3, 1, 16'd1));
   emit(3, encI(isaPkg::opSw, 1, 0, 16'h0410));
   expectStore(3, 32'h404, 32'd5);
   expectStore(3, 32'h408, 32'd9);
   expectStore(3, 32'h410, 32'd5);

   // r0 stays zero
   presetWord(4, 32'h508, 32'hdead_beef);
   emit(4, encI(isaPkg::opAddi, 0, 0, 16'h0033));
   emit(4, encI(isaPkg::opAddi, 1, 0, 16'd4));
   emit(4, encI(isaPkg::opSw, 0, 0, 16'h0500));
   emit(4, encR(isaPkg::opSpecial, isaPkg::fnOr, 0, 1, 1));
   emit(4, encR(isaPkg::opSpecial, isaPkg::fnAdd, 2, 0, 1));
   emit(4, encI(isaPkg::opSw, 2, 0, 16'h0504));
   emit(4, encI(isaPkg::opLw, 0, 0, 16'h0508));
   emit(4, encI(isaPkg::opSw, 0, 0, 16'h050c));
   expectStore(4, 32'h500, 32'd0);
   expectStore(4, 32'h504, 32'd4);
   expectStore(4, 32'h50c, 32'd0);
endtask

`endif

/* test/pipelineTb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module pipelineTb;

   logic                       Clock;
   logic                       reset;
   logic                       loadEnable;
   logic [`IMEM_ADDR_BITS-1:0] loadAddr;
   isaPkg::instruction         loadData;
   logic                       ack;
   isaPkg::word                datMiso;
   logic                       cyc;
   logic                       stb;
   logic                       we;
   logic [`WB_ADDR_WIDTH-1:0]  adr;
   isaPkg::word                datMosi;

   `include "tbPrograms.svh"

   // Slave model data memory
   // Unwritten words read back as the inverted address
   isaPkg::word dataMem [logic [`WB_ADDR_WIDTH-1:0]];
   int          waitLeft;
   logic        active;
   logic        collecting;
   int          cur;
   int          storeIndex;
   int          testErrors;
   int          passCount;
   int          failCount;

   pipelineTop u_dut (
      .Clock      (Clock),
      .reset      (reset),
      .loadEnable (loadEnable),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .ack        (ack),
      .datMiso    (datMiso),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .datMosi    (datMosi)
   );

   initial begin
      Clock = 1'b0;
      forever #20 Clock = ~Clock;
   end

   task automatic checkStore();
      if (collecting) begin
         assert (storeIndex < storeCount[cur]) else begin
            $display("test %0d: unexpected extra store to %h", cur, adr);
            testErrors++;
         end
         if (storeIndex < storeCount[cur]) begin
            assert (adr == storeAddr[cur][storeIndex]) else begin
               $display("error: adr got %h expected %h (test %0d, store %0d)",
                        adr, storeAddr[cur][storeIndex], cur, storeIndex);
               testErrors++;
            end
            assert (datMosi == storeData[cur][storeIndex]) else begin
               $display("error: datMosi got %h expected %h (test %0d, store %0d)",
                        datMosi, storeData[cur][storeIndex], cur, storeIndex);
               testErrors++;
            end
         end
         storeIndex++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Wishbone slave with 0 to 3 wait cycles before ack

   always @(negedge Clock) begin
      if (ack) begin
         ack    = 1'b0;
         active = 1'b0;
      end else if (cyc && stb) begin
         if (!active) begin
            active   = 1'b1;
            waitLeft = int'($urandom % 4);
         end
         if (waitLeft == 0) begin
            ack = 1'b1;
            if (we) begin
               dataMem[adr] = datMosi;
               checkStore();
            end else if (dataMem.exists(adr)) begin
               datMiso = dataMem[adr];
            end else begin
               datMiso = ~isaPkg::word'(adr);
            end
         end else begin
            waitLeft--;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////////
   // One program from the table

   task automatic runTest(int t);
      int cycles;
      cur        = t;
      collecting = 1'b0;
      @(negedge Clock);
      reset = 1'b1;
      for (int i = 0; i < 2 ** `IMEM_ADDR_BITS; i++) begin
         @(negedge Clock);
         loadEnable = 1'b1;
         loadAddr   = `IMEM_ADDR_BITS'(i);
         if (i < progLen[t]) begin
            loadData = progWords[t][i];
         end else begin
            // beq r0,r0,-1 spins in place
            loadData = encI(isaPkg::opBeq, 0, 0, 16'hffff);
         end
      end
      @(negedge Clock);
      loadEnable = 1'b0;
      repeat (10) @(negedge Clock);
      dataMem.delete();
      for (int i = 0; i < presetCount[t]; i++) begin
         dataMem[presetAddr[t][i]] = presetData[t][i];
      end
      storeIndex = 0;
      testErrors = 0;
      collecting = 1'b1;
      reset      = 1'b0;

      cycles = 0;
      while (storeIndex < storeCount[t] && cycles < 500) begin
         @(posedge Clock);
         cycles++;
      end
      assert (storeIndex >= storeCount[t]) else begin
         $display("test %0d: timed out, only %0d of %0d expected stores arrived",
                  t, storeIndex, storeCount[t]);
         testErrors++;
      end
      // Extra stores would show up here
      repeat (20) @(posedge Clock);
      collecting = 1'b0;

      if (testErrors == 0) begin
         $display("test %0d ok, %0d stores", t, storeIndex);
         passCount++;
      end else begin
         $display("test %0d failed with %0d errors", t, testErrors);
         failCount++;
      end
   endtask

   initial begin
      void'($urandom(32'hf848_bd38));
      reset      = 1'b1;
      loadEnable = 1'b0;
      loadAddr   = '0;
      loadData   = '0;
      ack        = 1'b0;
      datMiso    = '0;
      active     = 1'b0;
      waitLeft   = 0;
      collecting = 1'b0;
      cur        = 0;
      storeIndex = 0;
      testErrors = 0;
      passCount  = 0;
      failCount  = 0;
      fillPrograms();

      for (int t = 0; t < NumTests; t++) begin
         runTest(t);
      end

      $display("tests run %0d, passed %0d, failed %0d", NumTests, passCount, failCount);
      if (failCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+rtl
+incdir+test
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/hazardDetection.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipelineTop.sv
test/pipelineTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := pipelineTb
FILELIST  := all.f
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh test/*.sv test/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
